//--- include/switch_consts.svh
`ifndef SWITCH_CONSTS_SVH
`define SWITCH_CONSTS_SVH

// input and output port count
`define SW_N_PORTS       4
`define SW_PORT_W        2

// packet word
`define SW_DATA_W        16

// shared buffer paging
`define SW_PAGE_WORDS    8
`define SW_N_PAGES       64
`define SW_PAGE_W        6
`define SW_FREE_CNT_W    7

// payload length field, 1 to 31 words
`define SW_LEN_W         5
// header plus 31 words spans four pages
`define SW_MAX_PKT_PAGES 4

`endif

//--- logic/switch_pkg.sv
`include "switch_consts.svh"

package switch_pkg;

    typedef logic [`SW_PAGE_W-1:0] page_id_t;
    typedef logic [`SW_PORT_W-1:0] port_id_t;

    // first word of every packet
    typedef struct packed {
        port_id_t                                     dest;
        // payload words after the header
        logic [`SW_LEN_W-1:0]                         length;
        logic [`SW_DATA_W-`SW_PORT_W-`SW_LEN_W-1:0]  spare;
    } pkt_hdr_t;

    // plain data, or a header when the word carries sop
    typedef union packed {
        logic [`SW_DATA_W-1:0] raw;
        pkt_hdr_t              hdr;
    } pkt_word_u;

endpackage

//--- logic/pkt_buffer.sv
`timescale 1ns/10ps
`include "switch_consts.svh"

module pkt_buffer #(
    parameter int ADDR_W = `SW_PAGE_W + $clog2(`SW_PAGE_WORDS)
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [ADDR_W-1:0]     wr_addr,
    input  logic [`SW_DATA_W-1:0] wr_data,
    input  logic                  rd_en,
    input  logic [ADDR_W-1:0]     rd_addr,
    output logic [`SW_DATA_W-1:0] rd_data
);

    // address is page number over word in page
    logic [`SW_DATA_W-1:0] mem [`SW_N_PAGES*`SW_PAGE_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old word on a same-address write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- logic/free_page_list.sv
`timescale 1ns/10ps
`include "switch_consts.svh"

module free_page_list import switch_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      alloc,
    output page_id_t                  alloc_page,
    input  logic                      release_en,
    input  page_id_t                  release_page,
    output logic [`SW_FREE_CNT_W-1:0] free_count
);

    // ring of free page numbers
    page_id_t               list [`SW_N_PAGES];
    // list depth equals page count, so pointers share the page width
    logic [`SW_PAGE_W-1:0]  rd_ptr;
    logic [`SW_PAGE_W-1:0]  wr_ptr;

    // next free page is always on show
    assign alloc_page = list[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `SW_N_PAGES; i++) begin
                list[i] <= page_id_t'(i);
            end
        end else if (release_en) begin
            list[wr_ptr] <= release_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            // full list after reset, so wr_ptr meets rd_ptr
            wr_ptr     <= '0;
            free_count <= `SW_FREE_CNT_W'(`SW_N_PAGES);
        end else begin
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (release_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            free_count <= free_count + `SW_FREE_CNT_W'(release_en)
                          - `SW_FREE_CNT_W'(alloc);
        end
    end

    // writer checks the count at each header, so the list never runs dry
    assert property (@(posedge clk) disable iff (!rst_n)
        alloc |-> free_count != '0);

    // reader returns each page once
    assert property (@(posedge clk) disable iff (!rst_n)
        release_en |-> free_count != `SW_FREE_CNT_W'(`SW_N_PAGES));

endmodule

//--- logic/out_queues.sv
`timescale 1ns/10ps
`include "switch_consts.svh"

module out_queues import switch_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        link_wr,
    input  page_id_t                    link_from,
    input  page_id_t                    link_to,
    input  logic                        enq,
    input  port_id_t                    enq_dest,
    input  page_id_t                    enq_head,
    input  page_id_t                    enq_tail,
    input  logic                        deq,
    input  port_id_t                    deq_port,
    output page_id_t [`SW_N_PORTS-1:0]  head_page,
    input  page_id_t                    link_rd_page,
    output page_id_t                    link_next,
    output logic [`SW_N_PORTS-1:0]      nonempty
);

    // next page of a packet, or head page of the next packet in queue
    page_id_t                   link [`SW_N_PAGES];
    page_id_t                   tail [`SW_N_PORTS];
    // packets waiting per output
    logic [`SW_FREE_CNT_W-1:0]  count [`SW_N_PORTS];
    logic [`SW_N_PORTS-1:0]     enq_sel;
    logic [`SW_N_PORTS-1:0]     deq_sel;

    assign enq_sel   = enq ? (`SW_N_PORTS'(1) << enq_dest) : '0;
    assign deq_sel   = deq ? (`SW_N_PORTS'(1) << deq_port) : '0;
    assign link_next = link[link_rd_page];

    always_comb begin
        for (int p = 0; p < `SW_N_PORTS; p++) begin
            nonempty[p] = count[p] != '0;
        end
    end

    // page chaining and tail chaining never fall in one cycle
    always_ff @(posedge clk) begin
        if (link_wr) begin
            link[link_from] <= link_to;
        end else if (enq && nonempty[enq_dest]) begin
            link[tail[enq_dest]] <= enq_head;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `SW_N_PORTS; p++) begin
            if (enq_sel[p]) begin
                tail[p] <= enq_tail;
            end
            // empty queue, or its last packet leaves as this one lands
            if (enq_sel[p] && (count[p] == '0 || (deq_sel[p] && count[p] == 1))) begin
                head_page[p] <= enq_head;
            end else if (deq_sel[p]) begin
                head_page[p] <= link_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `SW_N_PORTS; p++) begin
                count[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `SW_N_PORTS; p++) begin
                count[p] <= count[p] + `SW_FREE_CNT_W'(enq_sel[p])
                            - `SW_FREE_CNT_W'(deq_sel[p]);
            end
        end
    end

    // scheduler only starts on a nonempty queue, dequeue comes at its eop
    assert property (@(posedge clk) disable iff (!rst_n)
        deq |-> nonempty[deq_port]);

endmodule

//--- logic/switch_ctrl.sv
`timescale 1ns/10ps
`include "switch_consts.svh"

module switch_ctrl import switch_pkg::*; #(
    parameter int IDX_W  = $clog2(`SW_PAGE_WORDS),
    parameter int ADDR_W = `SW_PAGE_W + IDX_W
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`SW_N_PORTS-1:0]                  wr_sop,
    input  logic [`SW_N_PORTS-1:0]                  wr_eop,
    input  logic [`SW_N_PORTS-1:0]                  wr_vld,
    input  logic [`SW_N_PORTS-1:0][`SW_DATA_W-1:0]  wr_data,
    output logic [`SW_N_PORTS-1:0]                  full,
    input  logic [`SW_N_PORTS-1:0]                  ready,
    output logic [`SW_N_PORTS-1:0]                  rd_sop,
    output logic [`SW_N_PORTS-1:0]                  rd_eop,
    output logic [`SW_N_PORTS-1:0]                  rd_vld,
    output logic [`SW_N_PORTS-1:0][`SW_DATA_W-1:0]  rd_data,
    output logic                                    buf_wr_en,
    output logic [ADDR_W-1:0]                       buf_wr_addr,
    output logic [`SW_DATA_W-1:0]                   buf_wr_data,
    output logic                                    buf_rd_en,
    output logic [ADDR_W-1:0]                       buf_rd_addr,
    input  logic [`SW_DATA_W-1:0]                   buf_rd_data,
    output logic                                    alloc,
    input  page_id_t                                alloc_page,
    output logic                                    release_en,
    output page_id_t                                release_page,
    input  logic [`SW_FREE_CNT_W-1:0]               free_count,
    output logic                                    link_wr,
    output page_id_t                                link_from,
    output page_id_t                                link_to,
    output logic                                    enq,
    output port_id_t                                enq_dest,
    output page_id_t                                enq_head,
    output page_id_t                                enq_tail,
    output logic                                    deq,
    output port_id_t                                deq_port,
    input  page_id_t [`SW_N_PORTS-1:0]              head_page,
    output page_id_t                                link_rd_page,
    input  page_id_t                                link_next,
    input  logic [`SW_N_PORTS-1:0]                  nonempty
);

    // write side
    port_id_t               in_ptr;
    logic                   in_busy;
    logic                   in_open;
    pkt_word_u              in_word;
    logic                   hdr_acc;
    logic                   pay_acc;
    page_id_t               wr_pg;
    page_id_t               wr_head;
    port_id_t               wr_dest;
    logic [IDX_W-1:0]       wr_idx;
    logic [`SW_LEN_W-1:0]   wr_left;

    assign in_word = wr_data[in_ptr];
    // room for the largest packet before a header is taken
    assign in_open = !in_busy && free_count >= `SW_FREE_CNT_W'(`SW_MAX_PKT_PAGES);
    assign full    = ~({`SW_N_PORTS{in_open}} & (`SW_N_PORTS'(1) << in_ptr));
    assign hdr_acc = in_open && wr_vld[in_ptr] && wr_sop[in_ptr];
    assign pay_acc = in_busy && wr_vld[in_ptr];

    // header, and every payload word landing on index 0, opens a page
    assign alloc       = hdr_acc || (pay_acc && wr_idx == '0);
    assign buf_wr_en   = hdr_acc || pay_acc;
    assign buf_wr_addr = {alloc ? alloc_page : wr_pg, wr_idx};
    assign buf_wr_data = in_word.raw;

    // chain old page to new one
    assign link_wr   = pay_acc && wr_idx == '0;
    assign link_from = wr_pg;
    assign link_to   = alloc_page;

    // registers hold through the enqueue cycle
    assign enq_dest = wr_dest;
    assign enq_head = wr_head;
    assign enq_tail = wr_pg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ptr  <= '0;
            in_busy <= 1'b0;
            wr_idx  <= '0;
            enq     <= 1'b0;
        end else begin
            // enqueue one cycle after the last word
            enq <= pay_acc && wr_left == `SW_LEN_W'(1);
            if (!in_busy && !hdr_acc) begin
                in_ptr <= in_ptr + 1'b1;
            end
            if (hdr_acc) begin
                in_busy <= 1'b1;
                wr_idx  <= IDX_W'(1);
            end else if (pay_acc) begin
                if (wr_left == `SW_LEN_W'(1)) begin
                    in_busy <= 1'b0;
                    // next header starts a page at index 0
                    wr_idx  <= '0;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            wr_pg <= alloc_page;
        end
        if (hdr_acc) begin
            wr_head <= alloc_page;
            wr_dest <= in_word.hdr.dest;
            wr_left <= in_word.hdr.length;
        end else if (pay_acc) begin
            wr_left <= wr_left - 1'b1;
        end
    end

    // read side
    port_id_t               out_ptr;
    logic                   rd_busy;
    logic                   rd_start;
    logic                   rd_hdr;
    logic                   rd_final;
    logic                   page_end;
    port_id_t               rd_port;
    page_id_t               rd_pg;
    logic [IDX_W-1:0]       rd_idx;
    logic [`SW_LEN_W-1:0]   rd_cnt;
    logic [`SW_LEN_W-1:0]   rd_last;
    logic [`SW_LEN_W-1:0]   last_idx;
    pkt_word_u              rd_word;
    // tags for the word now in buf_rd_data
    logic                   s1_vld;
    logic                   s1_sop;
    logic                   s1_eop;
    port_id_t               s1_port;

    assign rd_word  = buf_rd_data;
    assign rd_start = !rd_busy && ready[out_ptr] && nonempty[out_ptr];
    // header shows up the cycle after start and gives the length
    assign last_idx = rd_hdr ? rd_word.hdr.length : rd_last;
    assign rd_final = rd_busy && rd_cnt == last_idx;
    assign page_end = rd_idx == IDX_W'(`SW_PAGE_WORDS - 1);

    assign buf_rd_en   = rd_start || rd_busy;
    assign buf_rd_addr = rd_start ? {head_page[out_ptr], IDX_W'(0)} : {rd_pg, rd_idx};

    // page goes back once its last word is read
    assign release_en   = rd_busy && (page_end || rd_final);
    assign release_page = rd_pg;
    assign link_rd_page = rd_pg;
    // queue head moves to the link of the last page
    assign deq          = rd_final;
    assign deq_port     = rd_port;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_ptr <= '0;
            rd_busy <= 1'b0;
            rd_hdr  <= 1'b0;
            s1_vld  <= 1'b0;
            s1_sop  <= 1'b0;
            s1_eop  <= 1'b0;
            rd_vld  <= '0;
            rd_sop  <= '0;
            rd_eop  <= '0;
        end else begin
            if (!rd_busy) begin
                out_ptr <= out_ptr + 1'b1;
            end
            if (rd_start) begin
                rd_busy <= 1'b1;
            end else if (rd_final) begin
                rd_busy <= 1'b0;
            end
            rd_hdr <= rd_start;
            s1_vld <= buf_rd_en;
            s1_sop <= rd_start;
            s1_eop <= rd_final;
            rd_vld <= s1_vld ? (`SW_N_PORTS'(1) << s1_port) : '0;
            rd_sop <= s1_sop ? (`SW_N_PORTS'(1) << s1_port) : '0;
            rd_eop <= s1_eop ? (`SW_N_PORTS'(1) << s1_port) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            rd_port <= out_ptr;
            rd_pg   <= head_page[out_ptr];
            rd_idx  <= IDX_W'(1);
            rd_cnt  <= `SW_LEN_W'(1);
        end else if (rd_busy) begin
            rd_idx <= rd_idx + 1'b1;
            rd_cnt <= rd_cnt + 1'b1;
            if (page_end) begin
                rd_pg <= link_next;
            end
        end
        if (rd_hdr) begin
            rd_last <= rd_word.hdr.length;
        end
        s1_port <= rd_start ? out_ptr : rd_port;
        if (s1_vld) begin
            rd_data[s1_port] <= buf_rd_data;
        end
    end

    // eop must land on the word the header length counts to
    assert property (@(posedge clk) disable iff (!rst_n)
        pay_acc |-> wr_eop[in_ptr] == (wr_left == `SW_LEN_W'(1)));

endmodule

//--- logic/switch_top.sv
`timescale 1ns/10ps
`include "switch_consts.svh"

module switch_top import switch_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`SW_N_PORTS-1:0]                  wr_sop,
    input  logic [`SW_N_PORTS-1:0]                  wr_eop,
    input  logic [`SW_N_PORTS-1:0]                  wr_vld,
    input  logic [`SW_N_PORTS-1:0][`SW_DATA_W-1:0]  wr_data,
    output logic [`SW_N_PORTS-1:0]                  full,
    input  logic [`SW_N_PORTS-1:0]                  ready,
    output logic [`SW_N_PORTS-1:0]                  rd_sop,
    output logic [`SW_N_PORTS-1:0]                  rd_eop,
    output logic [`SW_N_PORTS-1:0]                  rd_vld,
    output logic [`SW_N_PORTS-1:0][`SW_DATA_W-1:0]  rd_data
);

    localparam int ADDR_W = `SW_PAGE_W + $clog2(`SW_PAGE_WORDS);

    // buffer
    logic                       buf_wr_en;
    logic [ADDR_W-1:0]          buf_wr_addr;
    logic [`SW_DATA_W-1:0]      buf_wr_data;
    logic                       buf_rd_en;
    logic [ADDR_W-1:0]          buf_rd_addr;
    logic [`SW_DATA_W-1:0]      buf_rd_data;
    // free list
    logic                       alloc;
    page_id_t                   alloc_page;
    logic                       release_en;
    page_id_t                   release_page;
    logic [`SW_FREE_CNT_W-1:0]  free_count;
    // link table and queues
    logic                       link_wr;
    page_id_t                   link_from;
    page_id_t                   link_to;
    logic                       enq;
    port_id_t                   enq_dest;
    page_id_t                   enq_head;
    page_id_t                   enq_tail;
    logic                       deq;
    port_id_t                   deq_port;
    page_id_t [`SW_N_PORTS-1:0] head_page;
    page_id_t                   link_rd_page;
    page_id_t                   link_next;
    logic [`SW_N_PORTS-1:0]     nonempty;

    // wire names match the port names on the ctrl, list and queues
    switch_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (.*);

    pkt_buffer #(.ADDR_W(ADDR_W)) u_buf (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_en   (buf_rd_en),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    free_page_list u_free (.*);

    out_queues u_queues (.*);

endmodule

//--- dv/switch_tb.sv
`timescale 1ns/10ps
`include "switch_consts.svh"

module switch_tb import switch_pkg::*; ();

    localparam int N_PKTS         = 200;
    localparam int MAX_PKT_WORDS  = 32;
    // four cycles per word for write, read and gaps, plus the stall phases
    localparam int TIMEOUT_CYCLES = N_PKTS * MAX_PKT_WORDS * 4 + 4400;
    // packets sent before all outputs go not-ready
    localparam int WARM_PKTS      = 150;
    // longer than any packet, so all-full for this long means no pages left
    localparam int STALL_RUN      = 40;
    // whole buffer read out, with room for the gaps between packets
    localparam int DRAIN_CYCLES   = `SW_N_PAGES * `SW_PAGE_WORDS * 2;

    logic                                   clk;
    logic                                   rst_n;
    logic [`SW_N_PORTS-1:0]                 wr_sop;
    logic [`SW_N_PORTS-1:0]                 wr_eop;
    logic [`SW_N_PORTS-1:0]                 wr_vld;
    logic [`SW_N_PORTS-1:0][`SW_DATA_W-1:0] wr_data;
    logic [`SW_N_PORTS-1:0]                 full;
    logic [`SW_N_PORTS-1:0]                 ready;
    logic [`SW_N_PORTS-1:0]                 rd_sop;
    logic [`SW_N_PORTS-1:0]                 rd_eop;
    logic [`SW_N_PORTS-1:0]                 rd_vld;
    logic [`SW_N_PORTS-1:0][`SW_DATA_W-1:0] rd_data;

    logic [15:0]            lfsr;
    // expected words per output, in acceptance order
    logic [`SW_DATA_W-1:0]  sb [`SW_N_PORTS][$];
    // words still due in the packet now leaving each output
    int                     words_left [`SW_N_PORTS];
    int                     sent;
    int                     cycles;
    int                     step;
    logic                   checking;
    logic                   bp_active;
    logic                   ready_rand;

    switch_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("Error: %s expected %0h actual %0h", name, expected, actual);
        stop_run();
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[14:0], fb};
        end
        return val;
    endfunction

    function automatic int pending();
        int total;
        total = 0;
        for (int p = 0; p < `SW_N_PORTS; p++) begin
            total += sb[p].size();
        end
        return total;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        step++;
        // fresh ready pattern every 16 cycles
        if (ready_rand && step % 16 == 0) begin
            ready = `SW_N_PORTS'(rand_bits(`SW_N_PORTS));
        end
    endtask

    task automatic pick_packet(output int src, output int dest, output int len);
        src  = int'(rand_bits(`SW_PORT_W));
        dest = int'(rand_bits(`SW_PORT_W));
        len  = 0;
        // zero length is not a legal packet
        while (len == 0) begin
            len = int'(rand_bits(`SW_LEN_W));
        end
    endtask

    // got stays low if every full bit sits high for STALL_RUN cycles
    task automatic wait_slot(input int src, output logic got);
        int high_run;
        high_run = 0;
        got      = 1'b0;
        while (!got && high_run < STALL_RUN) begin
            if (!full[src]) begin
                got = 1'b1;
            end else begin
                high_run = (&full) ? high_run + 1 : 0;
                next_cycle();
            end
        end
    endtask

    task automatic send_packet(input int src, input int dest, input int len);
        pkt_word_u word;
        // random spare bits in the header
        word.raw        = rand_bits(`SW_DATA_W);
        word.hdr.dest   = port_id_t'(dest);
        word.hdr.length = `SW_LEN_W'(len);
        sb[dest].push_back(word.raw);
        wr_sop[src]  = 1'b1;
        wr_vld[src]  = 1'b1;
        wr_data[src] = word.raw;
        next_cycle();
        wr_sop[src] = 1'b0;
        for (int i = 1; i <= len; i++) begin
            // idle cycle inside the packet, one in four
            while (rand_bits(2) == 16'd3) begin
                wr_vld[src] = 1'b0;
                next_cycle();
            end
            word.raw = rand_bits(`SW_DATA_W);
            sb[dest].push_back(word.raw);
            wr_vld[src]  = 1'b1;
            wr_eop[src]  = (i == len);
            wr_data[src] = word.raw;
            next_cycle();
        end
        wr_vld[src] = 1'b0;
        wr_eop[src] = 1'b0;
        sent++;
    endtask

    task automatic send_one();
        int   src;
        int   dest;
        int   len;
        logic got;
        pick_packet(src, dest, len);
        got = 1'b0;
        while (!got) begin
            wait_slot(src, got);
        end
        send_packet(src, dest, len);
    endtask

    task automatic check_port(input int p);
        pkt_word_u want;
        logic      first;
        if (rd_vld[p]) begin
            assert (sb[p].size() != 0)
                else report_failure($sformatf("output %0d sent a word never queued", p));
            want.raw = sb[p].pop_front();
            assert (rd_data[p] == want.raw)
                else report_mismatch($sformatf("rd_data[%0d]", p), int'(want.raw),
                                     int'(rd_data[p]));
            // header opens a packet and gives its length
            first = (words_left[p] == 0);
            assert (rd_sop[p] == first)
                else report_mismatch($sformatf("rd_sop[%0d]", p), int'(first), int'(rd_sop[p]));
            if (first) begin
                words_left[p] = int'(want.hdr.length) + 1;
            end
            words_left[p]--;
            assert (rd_eop[p] == (words_left[p] == 0))
                else report_mismatch($sformatf("rd_eop[%0d]", p), int'(words_left[p] == 0),
                                     int'(rd_eop[p]));
        end else begin
            assert (words_left[p] == 0)
                else report_mismatch($sformatf("rd_vld_gap[%0d]", p), 1, 0);
            assert (!rd_sop[p] && !rd_eop[p])
                else report_failure($sformatf("output %0d framed a word without rd_vld", p));
        end
    endtask

    // outputs sampled mid-cycle, away from both edges of the drive
    always @(negedge clk) begin
        if (checking) begin
            assert ($countones(full) >= `SW_N_PORTS - 1)
                else report_failure("more than one input was offered a slot at once");
            if (bp_active) begin
                assert (rd_vld == '0)
                    else report_mismatch("bp_rd_vld", 0, int'(rd_vld));
            end
            for (int p = 0; p < `SW_N_PORTS; p++) begin
                check_port(p);
            end
        end
    end

    initial begin
        int   src;
        int   dest;
        int   len;
        int   drain;
        logic got;
        rst_n      = 1'b0;
        wr_sop     = '0;
        wr_eop     = '0;
        wr_vld     = '0;
        wr_data    = '0;
        ready      = '0;
        lfsr       = 16'd13;
        sent       = 0;
        step       = 0;
        checking   = 1'b0;
        bp_active  = 1'b0;
        ready_rand = 1'b0;
        for (int p = 0; p < `SW_N_PORTS; p++) begin
            words_left[p] = 0;
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        // quiet outputs, pointer on input 0 with every page free
        assert (rd_sop == '0 && rd_eop == '0 && rd_vld == '0)
            else report_mismatch("reset_rd", 0, int'({rd_sop, rd_eop, rd_vld}));
        assert (full == {{(`SW_N_PORTS-1){1'b1}}, 1'b0})
            else report_mismatch("reset_full", int'({{(`SW_N_PORTS-1){1'b1}}, 1'b0}),
                                 int'(full));
        checking = 1'b1;

        // mixed traffic with wandering ready
        ready_rand = 1'b1;
        ready      = `SW_N_PORTS'(rand_bits(`SW_N_PORTS));
        while (sent < WARM_PKTS) begin
            send_one();
        end

        // all outputs stalled, fill the buffer until no input gets a slot
        ready_rand = 1'b0;
        ready      = '0;
        repeat (STALL_RUN) next_cycle();
        bp_active = 1'b1;
        got       = 1'b1;
        while (got) begin
            pick_packet(src, dest, len);
            wait_slot(src, got);
            if (got) begin
                send_packet(src, dest, len);
            end
        end
        repeat (20) begin
            assert (&full)
                else report_mismatch("bp_full", (1 << `SW_N_PORTS) - 1, int'(full));
            next_cycle();
        end

        // release the outputs and finish the packet count
        bp_active = 1'b0;
        ready     = '1;
        while (sent < N_PKTS) begin
            send_one();
        end
        // buffer must empty in bounded time with every output ready
        drain = 0;
        while (pending() != 0 && drain < DRAIN_CYCLES) begin
            next_cycle();
            drain++;
        end
        // nothing stray after the last packet
        repeat (STALL_RUN) next_cycle();
        assert (pending() == 0)
            else report_mismatch("sb_empty", 0, pending());
        $display("No errors");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
logic/switch_pkg.sv
logic/pkt_buffer.sv
logic/free_page_list.sv
logic/out_queues.sv
logic/switch_ctrl.sv
logic/switch_top.sv
dv/switch_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module switch_tb -f src.f -o switch_sim &&
./obj_dir/switch_sim | tee /dev/stderr | grep -x "No errors" > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
